//--- Makefile
# Verilator flow for chunk_fetch, override any variable on the command line

VERILATOR ?= verilator
FLIST ?= chunk_fetch.f
RTL_TOP ?= chunk_fetch
TB_TOP ?= tb_chunk_fetch
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FLIST)

# the log decides pass or fail
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- chunk_fetch.f
src/chunk_pkg.sv
src/chunk_if.sv
src/row_sequencer.sv
src/chunk_row.sv
src/cmd_fifo.sv
src/chunk_fetch.sv
tests/tb_checker.sv
tests/tb_chunk_fetch.sv

//--- src/chunk_fetch.sv
// window fetch top level
// turns a 2D window job into a stream of memory commands through
// the row sequencer, the row chunker and the command buffer

`timescale 1ns/1ns

module chunk_fetch #(
	parameter int ADDR_BW = chunk_pkg::DEF_ADDR_BW,
	parameter int LINE_SIZE = chunk_pkg::DEF_LINE_SIZE,
	parameter int VSIZE = chunk_pkg::DEF_VSIZE
) (
	input  logic                         i_clk,
	input  logic                         i_reset,
	// job side
	input  logic                         i_job_rdy,
	output logic                         o_job_ack,
	input  logic [ADDR_BW-1:0]           i_base,
	input  logic [ADDR_BW-1:0]           i_stride,
	input  logic [ADDR_BW-1:0]           i_rows,
	input  logic [ADDR_BW-1:0]           i_valid_rows,
	input  logic [ADDR_BW-1:0]           i_l,
	input  logic [ADDR_BW-1:0]           i_n,
	input  logic [ADDR_BW-1:0]           i_bound,
	input  logic                         i_wrap,
	input  logic [$clog2(VSIZE)-1:0]     i_pad,
	// command side
	output logic                         o_cmd_rdy,
	input  logic                         i_cmd_ack,
	output chunk_pkg::cmd_type_e         o_cmd_type,
	output logic                         o_cmd_islast,
	output logic [ADDR_BW-1:0]           o_cmd_addr,
	output logic [$clog2(LINE_SIZE)-1:0] o_cmd_addrofs,
	output logic [$clog2(VSIZE+1)-1:0]   o_cmd_len
);

	row_if #(.ADDR_BW(ADDR_BW), .VSIZE(VSIZE)) row_bus ();
	cmd_if #(.ADDR_BW(ADDR_BW), .LINE_SIZE(LINE_SIZE), .VSIZE(VSIZE)) cmd_bus ();

	// per-row pad is the same for the whole job
	assign row_bus.pad = i_pad;

	row_sequencer #(.ADDR_BW(ADDR_BW)) u_row_sequencer (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_job_rdy(i_job_rdy),
		.i_base(i_base),
		.i_stride(i_stride),
		.i_rows(i_rows),
		.i_valid_rows(i_valid_rows),
		.o_job_ack(o_job_ack),
		.row(row_bus.src)
	);

	chunk_row #(.ADDR_BW(ADDR_BW), .LINE_SIZE(LINE_SIZE), .VSIZE(VSIZE)) u_chunk_row (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_l(i_l),
		.i_n(i_n),
		.i_bound(i_bound),
		.i_wrap(i_wrap),
		.row(row_bus.dst),
		.cmd(cmd_bus.src)
	);

	cmd_fifo #(.ADDR_BW(ADDR_BW), .LINE_SIZE(LINE_SIZE), .VSIZE(VSIZE)) u_cmd_fifo (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_cmd_ack(i_cmd_ack),
		.in(cmd_bus.dst),
		.o_cmd_rdy(o_cmd_rdy),
		.o_cmd_type(o_cmd_type),
		.o_cmd_islast(o_cmd_islast),
		.o_cmd_addr(o_cmd_addr),
		.o_cmd_addrofs(o_cmd_addrofs),
		.o_cmd_len(o_cmd_len)
	);

endmodule

//--- src/chunk_if.sv
// row and command buses of the fetch chain
// both use the rdy/ack handshake and transfer when rdy and ack are high

`timescale 1ns/1ns

// one row descriptor from the sequencer to the row chunker
interface row_if #(
	parameter int ADDR_BW = 16,
	parameter int VSIZE = 8
);
	logic rdy;
	logic ack;
	// row start address
	logic [ADDR_BW-1:0] linear;
	logic islast;
	// garbage words after the row, narrower than VSIZE
	logic [$clog2(VSIZE)-1:0] pad;
	logic valid;

	// pad comes straight from the job ports
	modport src (output rdy, linear, islast, valid, input ack);
	modport dst (input rdy, linear, islast, pad, valid, output ack);
endinterface

// one memory command from the row chunker to the buffer
interface cmd_if #(
	parameter int ADDR_BW = 16,
	parameter int LINE_SIZE = 8,
	parameter int VSIZE = 8
);
	logic rdy;
	logic ack;
	chunk_pkg::cmd_type_e ctype;
	logic islast;
	// line aligned address plus offset inside the line
	logic [ADDR_BW-1:0] addr;
	logic [$clog2(LINE_SIZE)-1:0] addrofs;
	logic [$clog2(VSIZE+1)-1:0] len;

	modport src (output rdy, ctype, islast, addr, addrofs, len, input ack);
	modport dst (input rdy, ctype, islast, addr, addrofs, len, output ack);
endinterface

//--- src/chunk_pkg.sv
// chunk fetch shared definitions
// command kinds and default sizes for the window fetch chain

package chunk_pkg;

	// ====================
	// command kinds
	// ====================
	// fetch reads real data, wrap replicates the edge word,
	// zero fills with zeros and also marks the pad command
	typedef enum logic [1:0] {
		CMD_FETCH = 2'd0,
		CMD_WRAP  = 2'd1,
		CMD_ZERO  = 2'd2
	} cmd_type_e;

	// ====================
	// default sizes
	// ====================
	// address width in bits, compared as signed
	localparam int DEF_ADDR_BW = 16;
	// cache line size in words, power of two
	localparam int DEF_LINE_SIZE = 8;
	// longest command in words
	localparam int DEF_VSIZE = 8;

endpackage

//--- src/chunk_row.sv
// row chunker
// splits one row into left border, centre, right border and pad segments
// and cuts them into commands of at most VSIZE words
// without letting a centre command cross a cache line

`timescale 1ns/1ns

module chunk_row #(
	parameter int ADDR_BW = 16,
	parameter int LINE_SIZE = 8,
	parameter int VSIZE = 8
) (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic [ADDR_BW-1:0] i_l,
	input  logic [ADDR_BW-1:0] i_n,
	input  logic [ADDR_BW-1:0] i_bound,
	input  logic               i_wrap,
	row_if.dst                 row,
	cmd_if.src                 cmd
);

	localparam int C_BW = $clog2(LINE_SIZE);
	localparam int LEN_BW = $clog2(VSIZE + 1);

	// lowest set bit picks the first pending segment
	function automatic logic [3:0] lowest_bit(input logic [3:0] v);
		return v & (~v + 4'd1);
	endfunction

	function automatic logic signed [ADDR_BW-1:0] smin(
		input logic signed [ADDR_BW-1:0] a,
		input logic signed [ADDR_BW-1:0] b
	);
		return (a < b) ? a : b;
	endfunction

	logic signed [ADDR_BW-1:0] linear, l, r, br, b0, b1, c_start;
	logic signed [ADDR_BW-1:0] cur, cur_r, seg_end, cmd_pos, step, align, nxt, len_full;
	logic invalid, cut, init, advance, fin, none_left, busy_r;
	// segment bits: 0 left border, 1 centre, 2 right border, 3 pad
	logic [3:0] present, sel_cur, done_cur, next_sel, sel_r, done_r;
	chunk_pkg::cmd_type_e border_type;

	// ====================
	// segment bounds
	// ====================
	//   linear         br       absolute
	//      |--valid-----|
	//  |-------wanted-------|
	//  l                    r
	always_comb begin
		linear = row.linear;
		l = linear + $signed(i_l);
		r = l + $signed(i_n);
		br = linear + $signed(i_bound);
		// without data or wrap the whole row goes out as left border
		invalid = !(row.valid || i_wrap);
		cut = (r < linear) || invalid;
		b0 = cut ? r : linear;
		b1 = (!invalid && r > br) ? br : r;
		c_start = (l > b0) ? l : b0;
		present[0] = l < b0;
		present[1] = !cut && ($signed(i_l) < $signed(i_bound)) && (c_start < b1);
		present[2] = !invalid && (r > br);
		present[3] = row.pad != '0;
		if (i_wrap) begin
			border_type = chunk_pkg::CMD_WRAP;
		end else begin
			border_type = chunk_pkg::CMD_ZERO;
		end
	end

	// ====================
	// command generation
	// ====================
	always_comb begin
		// first cycle of a row works from l and the first segment
		init = row.rdy && !busy_r;
		sel_cur = init ? lowest_bit(present) : sel_r;
		done_cur = init ? sel_cur : done_r;
		cur = init ? l : cur_r;
		next_sel = lowest_bit(present & ~done_cur);
		none_left = next_sel == '0;
		case (1'b1)
			sel_cur[0]: begin
				seg_end = b0;
				cmd_pos = linear;
				cmd.ctype = border_type;
			end
			sel_cur[1]: begin
				seg_end = b1;
				cmd_pos = cur;
				cmd.ctype = chunk_pkg::CMD_FETCH;
			end
			sel_cur[2]: begin
				// replicate the last valid word
				seg_end = r;
				cmd_pos = br - 1'b1;
				cmd.ctype = border_type;
			end
			default: begin
				// pad is a single zero command
				seg_end = cur;
				cmd_pos = cur;
				cmd.ctype = chunk_pkg::CMD_ZERO;
			end
		endcase
		// stop at VSIZE, the segment end or in the centre the line end
		step = smin(cur + ADDR_BW'(VSIZE), seg_end);
		align = (cur & ~ADDR_BW'(LINE_SIZE - 1)) + ADDR_BW'(LINE_SIZE);
		nxt = sel_cur[1] ? smin(step, align) : step;
		advance = sel_cur[3] || (nxt == seg_end);
		fin = advance && none_left;
		len_full = nxt - cur;
	end

	assign cmd.len = sel_cur[3] ? LEN_BW'(row.pad) : len_full[LEN_BW-1:0];
	assign cmd.addr = cmd_pos & ~ADDR_BW'(LINE_SIZE - 1);
	assign cmd.addrofs = cmd_pos[C_BW-1:0];
	assign cmd.islast = fin && row.islast;
	assign cmd.rdy = row.rdy && (present != '0);
	// empty rows are acked without any command
	assign row.ack = (cmd.ack && fin) || (row.rdy && present == '0);

	// ====================
	// registers
	// ====================
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			busy_r <= 1'b0;
			done_r <= '0;
			sel_r <= '0;
		end else if (cmd.ack) begin
			if (fin) begin
				busy_r <= 1'b0;
				done_r <= '0;
				sel_r <= '0;
			end else begin
				busy_r <= 1'b1;
				done_r <= advance ? (done_cur | next_sel) : done_cur;
				sel_r <= advance ? next_sel : sel_cur;
			end
		end
	end

	// pad keeps the last issued address
	always_ff @(posedge i_clk) begin
		if (cmd.ack) begin
			cur_r <= (advance && next_sel[3]) ? cmd_pos : nxt;
		end
	end

endmodule

//--- src/cmd_fifo.sv
// command buffer
// two-entry register FIFO between the row chunker and the consumer
// with one cycle from input ack to output rdy

`timescale 1ns/1ns

module cmd_fifo #(
	parameter int ADDR_BW = 16,
	parameter int LINE_SIZE = 8,
	parameter int VSIZE = 8
) (
	input  logic                         i_clk,
	input  logic                         i_reset,
	input  logic                         i_cmd_ack,
	cmd_if.dst                           in,
	output logic                         o_cmd_rdy,
	output chunk_pkg::cmd_type_e         o_cmd_type,
	output logic                         o_cmd_islast,
	output logic [ADDR_BW-1:0]           o_cmd_addr,
	output logic [$clog2(LINE_SIZE)-1:0] o_cmd_addrofs,
	output logic [$clog2(VSIZE+1)-1:0]   o_cmd_len
);

	chunk_pkg::cmd_type_e         type_q [2];
	logic                         islast_q [2];
	logic [ADDR_BW-1:0]           addr_q [2];
	logic [$clog2(LINE_SIZE)-1:0] ofs_q [2];
	logic [$clog2(VSIZE+1)-1:0]   len_q [2];
	logic [1:0] count_r;
	logic wptr_r, rptr_r, wr, rd;

	// accept while not full
	assign in.ack = in.rdy && (count_r != 2'd2);
	assign wr = in.ack;
	assign rd = o_cmd_rdy && i_cmd_ack;
	assign o_cmd_rdy = count_r != 2'd0;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			count_r <= '0;
			wptr_r <= 1'b0;
			rptr_r <= 1'b0;
		end else begin
			wptr_r <= wptr_r ^ wr;
			rptr_r <= rptr_r ^ rd;
			case ({wr, rd})
				2'b10: count_r <= count_r + 2'd1;
				2'b01: count_r <= count_r - 2'd1;
				default: count_r <= count_r;
			endcase
		end
	end

	// ====================
	// storage
	// ====================
	always_ff @(posedge i_clk) begin
		if (wr) begin
			type_q[wptr_r] <= in.ctype;
			islast_q[wptr_r] <= in.islast;
			addr_q[wptr_r] <= in.addr;
			ofs_q[wptr_r] <= in.addrofs;
			len_q[wptr_r] <= in.len;
		end
	end

	// head entry
	assign o_cmd_type = type_q[rptr_r];
	assign o_cmd_islast = islast_q[rptr_r];
	assign o_cmd_addr = addr_q[rptr_r];
	assign o_cmd_addrofs = ofs_q[rptr_r];
	assign o_cmd_len = len_q[rptr_r];

endmodule

//--- src/row_sequencer.sv
// row sequencer
// walks the rows of a job and presents one registered row descriptor
// at a time and acks the job together with its final row

`timescale 1ns/1ns

module row_sequencer #(
	parameter int ADDR_BW = 16
) (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_job_rdy,
	input  logic [ADDR_BW-1:0] i_base,
	input  logic [ADDR_BW-1:0] i_stride,
	input  logic [ADDR_BW-1:0] i_rows,
	input  logic [ADDR_BW-1:0] i_valid_rows,
	output logic               o_job_ack,
	row_if.src                 row
);

	logic               rdy_r;
	logic [ADDR_BW-1:0] cnt_r;
	logic [ADDR_BW-1:0] cnt_nxt;
	logic [ADDR_BW-1:0] linear_r;
	logic               valid_r;
	logic               islast_r;

	// ====================
	// row state
	// ====================
	assign cnt_nxt = cnt_r + 1'b1;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			rdy_r <= 1'b0;
			cnt_r <= '0;
			valid_r <= 1'b0;
			islast_r <= 1'b0;
		end else if (!rdy_r) begin
			// start a new job at row 0 when idle
			if (i_job_rdy) begin
				rdy_r <= 1'b1;
				cnt_r <= '0;
				valid_r <= i_valid_rows != '0;
				islast_r <= i_rows == 1;
			end
		end else if (row.ack) begin
			// drop back to idle after the last row
			if (islast_r) begin
				rdy_r <= 1'b0;
			end
			cnt_r <= cnt_nxt;
			valid_r <= cnt_nxt < i_valid_rows;
			islast_r <= cnt_nxt == i_rows - 1'b1;
		end
	end

	// running row start address
	always_ff @(posedge i_clk) begin
		if (!rdy_r && i_job_rdy) begin
			linear_r <= i_base;
		end else if (rdy_r && row.ack) begin
			linear_r <= linear_r + i_stride;
		end
	end

	// ====================
	// outputs
	// ====================
	assign row.rdy = rdy_r;
	assign row.linear = linear_r;
	assign row.valid = valid_r;
	assign row.islast = islast_r;
	assign o_job_ack = rdy_r && row.ack && islast_r;

endmodule

//--- tests/tb_checker.sv
// command checker
// expands each job into its expected commands and compares them
// with every transfer on the command port

`timescale 1ns/1ns

module tb_checker #(
	parameter int ADDR_BW = 16,
	parameter int LINE_SIZE = 8,
	parameter int VSIZE = 8
) (
	input  logic                         i_clk,
	input  int                           i_test_id,
	input  logic                         i_job_rdy,
	input  logic                         i_job_ack,
	input  logic [ADDR_BW-1:0]           i_base,
	input  logic [ADDR_BW-1:0]           i_stride,
	input  logic [ADDR_BW-1:0]           i_rows,
	input  logic [ADDR_BW-1:0]           i_valid_rows,
	input  logic [ADDR_BW-1:0]           i_l,
	input  logic [ADDR_BW-1:0]           i_n,
	input  logic [ADDR_BW-1:0]           i_bound,
	input  logic                         i_wrap,
	input  logic [$clog2(VSIZE)-1:0]     i_pad,
	input  logic                         i_cmd_rdy,
	input  logic                         i_cmd_ack,
	input  logic [1:0]                   i_cmd_type,
	input  logic                         i_cmd_islast,
	input  logic [ADDR_BW-1:0]           i_cmd_addr,
	input  logic [$clog2(LINE_SIZE)-1:0] i_cmd_addrofs,
	input  logic [$clog2(VSIZE+1)-1:0]   i_cmd_len,
	output int                           o_mismatches,
	output int                           o_other_errors,
	output int                           o_pending
);

	localparam int OFS_BW = $clog2(LINE_SIZE);
	localparam int LEN_BW = $clog2(VSIZE + 1);

	// same field order as the command port
	typedef struct packed {
		logic [1:0]         ctype;
		logic               islast;
		logic [ADDR_BW-1:0] addr;
		logic [OFS_BW-1:0]  ofs;
		logic [LEN_BW-1:0]  len;
	} cmd_t;

	cmd_t exp_q[$];
	int mismatches = 0;
	int other_errors = 0;
	int pending = 0;
	bit job_open = 1'b0;

	assign o_mismatches = mismatches;
	assign o_other_errors = other_errors;
	assign o_pending = pending;

	function automatic string test_label(input int id);
		case (id)
			0: return "fixed";
			1: return "fixed_stalled";
			default: return "random_stalled";
		endcase
	endfunction

	function automatic string cmd_text(input cmd_t c);
		return $sformatf("type %0d last %0b addr %h ofs %0d len %0d",
			c.ctype, c.islast, c.addr, c.ofs, c.len);
	endfunction

	// address split into line base and offset inside the line
	function automatic void push_cmd(input chunk_pkg::cmd_type_e ctype, input int pos,
		input int len);
		cmd_t c;
		c.ctype = ctype;
		c.islast = 1'b0;
		c.addr = ADDR_BW'(pos & ~(LINE_SIZE - 1));
		c.ofs = OFS_BW'(pos & (LINE_SIZE - 1));
		c.len = LEN_BW'(len);
		exp_q.push_back(c);
	endfunction

	// ====================
	// reference model
	// ====================
	function automatic void expand_job(
		input int base,
		input int stride,
		input int rows,
		input int vrows,
		input int il,
		input int n,
		input int bound,
		input bit wrap,
		input int pad
	);
		int linear, l, r, br, b0, b1, pos, last, step, line_end, first;
		bit inval, cut;
		chunk_pkg::cmd_type_e btype;
		cmd_t tail;
		first = exp_q.size();
		btype = wrap ? chunk_pkg::CMD_WRAP : chunk_pkg::CMD_ZERO;
		for (int k = 0; k < rows; k++) begin
			linear = base + k * stride;
			l = linear + il;
			r = l + n;
			br = linear + bound;
			// without data or wrap the whole width is left border
			inval = (k >= vrows) && !wrap;
			cut = inval || (r < linear);
			b0 = cut ? r : linear;
			b1 = (!inval && r > br) ? br : r;
			pos = l;
			last = l;
			// every left border command points at the row start
			while (pos < b0) begin
				step = (pos + VSIZE < b0) ? pos + VSIZE : b0;
				push_cmd(btype, linear, step - pos);
				last = linear;
				pos = step;
			end
			// centre commands are cut at VSIZE and at the next line start
			if (!cut && il < bound) begin
				while (pos < b1) begin
					step = (pos + VSIZE < b1) ? pos + VSIZE : b1;
					line_end = (pos & ~(LINE_SIZE - 1)) + LINE_SIZE;
					if (line_end < step) begin
						step = line_end;
					end
					push_cmd(chunk_pkg::CMD_FETCH, pos, step - pos);
					last = pos;
					pos = step;
				end
			end
			// right border repeats the last valid word
			if (!inval && r > br) begin
				while (pos < r) begin
					step = (pos + VSIZE < r) ? pos + VSIZE : r;
					push_cmd(btype, br - 1, step - pos);
					last = br - 1;
					pos = step;
				end
			end
			// pad sits at the last issued address
			if (pad != 0) begin
				push_cmd(chunk_pkg::CMD_ZERO, last, pad);
			end
		end
		// end of job marker on the final command only
		if (exp_q.size() > first) begin
			tail = exp_q.pop_back();
			tail.islast = 1'b1;
			exp_q.push_back(tail);
		end
	endfunction

	// ====================
	// compare
	// ====================
	// sampled mid cycle when all handshake signals have settled
	always @(negedge i_clk) begin
		cmd_t got;
		cmd_t want;
		// a job opens on the first cycle its rdy is seen
		if (i_job_rdy && !job_open) begin
			expand_job(int'(i_base), int'(i_stride), int'(i_rows), int'(i_valid_rows),
				int'($signed(i_l)), int'(i_n), int'(i_bound), i_wrap, int'(i_pad));
			job_open = 1'b1;
		end
		if (i_job_ack) begin
			if (!job_open) begin
				other_errors++;
				$display("%s: job ack seen while no job was open", test_label(i_test_id));
			end
			job_open = 1'b0;
		end
		if (i_cmd_rdy && i_cmd_ack) begin
			got = {i_cmd_type, i_cmd_islast, i_cmd_addr, i_cmd_addrofs, i_cmd_len};
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("%s: extra command arrived with none expected, %s",
					test_label(i_test_id), cmd_text(got));
			end else begin
				want = exp_q.pop_front();
				if (got !== want) begin
					mismatches++;
					$display("** Error %s: expected %s, actual %s",
						test_label(i_test_id), cmd_text(want), cmd_text(got));
				end
			end
		end
		pending = exp_q.size();
	end

endmodule

//--- tests/tb_chunk_fetch.sv
// window fetch testbench
// sends fixed and random jobs back to back with and without
// consumer stalls and reports the checker's counts

`timescale 1ns/1ns

module tb_chunk_fetch;

	localparam int ADDR_BW = chunk_pkg::DEF_ADDR_BW;
	localparam int LINE_SIZE = chunk_pkg::DEF_LINE_SIZE;
	localparam int VSIZE = chunk_pkg::DEF_VSIZE;
	// cycles any single wait may take
	localparam int TIMEOUT = 2000;
	localparam int NUM_RAND = 12;

	// one job with offsets as plain integers
	typedef struct packed {
		int base;
		int stride;
		int rows;
		int vrows;
		int il;
		int n;
		int bound;
		int pad;
		bit wrap;
	} job_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic job_rdy = 1'b0;
	logic job_ack;
	logic [ADDR_BW-1:0] base = '0;
	logic [ADDR_BW-1:0] stride = '0;
	logic [ADDR_BW-1:0] rows = '0;
	logic [ADDR_BW-1:0] valid_rows = '0;
	logic [ADDR_BW-1:0] win_l = '0;
	logic [ADDR_BW-1:0] win_n = '0;
	logic [ADDR_BW-1:0] bound = '0;
	logic wrap = 1'b0;
	logic [$clog2(VSIZE)-1:0] pad = '0;
	logic cmd_rdy;
	logic cmd_ack = 1'b0;
	chunk_pkg::cmd_type_e cmd_type;
	logic cmd_islast;
	logic [ADDR_BW-1:0] cmd_addr;
	logic [$clog2(LINE_SIZE)-1:0] cmd_addrofs;
	logic [$clog2(VSIZE+1)-1:0] cmd_len;

	int seed = 78;
	int test_id = 0;
	bit stall = 1'b0;
	bit abort = 1'b0;
	int timeouts = 0;
	int mismatches;
	int other_errors;
	int pending;
	job_t rand_jobs[NUM_RAND];

	always #5 clk = ~clk;

	chunk_fetch #(.ADDR_BW(ADDR_BW), .LINE_SIZE(LINE_SIZE), .VSIZE(VSIZE)) i_chunk_fetch (
		.i_clk(clk), .i_reset(reset),
		.i_job_rdy(job_rdy), .o_job_ack(job_ack),
		.i_base(base), .i_stride(stride), .i_rows(rows), .i_valid_rows(valid_rows),
		.i_l(win_l), .i_n(win_n), .i_bound(bound), .i_wrap(wrap), .i_pad(pad),
		.o_cmd_rdy(cmd_rdy), .i_cmd_ack(cmd_ack), .o_cmd_type(cmd_type),
		.o_cmd_islast(cmd_islast), .o_cmd_addr(cmd_addr),
		.o_cmd_addrofs(cmd_addrofs), .o_cmd_len(cmd_len)
	);

	tb_checker #(.ADDR_BW(ADDR_BW), .LINE_SIZE(LINE_SIZE), .VSIZE(VSIZE)) u_tb_checker (
		.i_clk(clk), .i_test_id(test_id),
		.i_job_rdy(job_rdy), .i_job_ack(job_ack),
		.i_base(base), .i_stride(stride), .i_rows(rows), .i_valid_rows(valid_rows),
		.i_l(win_l), .i_n(win_n), .i_bound(bound), .i_wrap(wrap), .i_pad(pad),
		.i_cmd_rdy(cmd_rdy), .i_cmd_ack(cmd_ack), .i_cmd_type(cmd_type),
		.i_cmd_islast(cmd_islast), .i_cmd_addr(cmd_addr),
		.i_cmd_addrofs(cmd_addrofs), .i_cmd_len(cmd_len),
		.o_mismatches(mismatches), .o_other_errors(other_errors), .o_pending(pending)
	);

	// the consumer stalls about one cycle in four when back-pressure is on
	always @(posedge clk) begin
		if (reset) begin
			cmd_ack <= 1'b0;
		end else if (stall) begin
			cmd_ack <= ($random(seed) & 3) != 0;
		end else begin
			cmd_ack <= 1'b1;
		end
	end

	function automatic int rand_below(input int m);
		return int'($unsigned($random(seed)) % m);
	endfunction

	// ====================
	// job driver
	// ====================
	// called right after a rising edge and returns on the edge after the job ack
	task automatic send_job(input job_t j);
		int cycles;
		if (abort) begin
			return;
		end
		job_rdy <= 1'b1;
		base <= ADDR_BW'(j.base);
		stride <= ADDR_BW'(j.stride);
		rows <= ADDR_BW'(j.rows);
		valid_rows <= ADDR_BW'(j.vrows);
		win_l <= ADDR_BW'(j.il);
		win_n <= ADDR_BW'(j.n);
		bound <= ADDR_BW'(j.bound);
		wrap <= j.wrap;
		pad <= $bits(pad)'(j.pad);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!job_ack && cycles < TIMEOUT);
		if (!job_ack) begin
			$display("job was not acked within %0d cycles", TIMEOUT);
			timeouts++;
			abort = 1'b1;
		end
		@(posedge clk);
	endtask

	// inside window, wrap and zero borders, invalid rows, pad, r below row start
	task automatic send_fixed();
		send_job('{16, 64, 2, 2, 3, 20, 40, 0, 1'b0});
		send_job('{100, 48, 3, 3, -5, 30, 20, 0, 1'b1});
		send_job('{100, 48, 3, 1, -5, 30, 20, 0, 1'b0});
		send_job('{200, 32, 2, 2, 2, 9, 16, 5, 1'b0});
		send_job('{300, 40, 2, 2, -20, 10, 16, 3, 1'b1});
	endtask

	// wait until every expected command has been seen
	task automatic drain_commands();
		int cycles;
		job_rdy <= 1'b0;
		cycles = 0;
		while (!abort && pending != 0 && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (!abort && pending != 0) begin
			$display("%0d expected commands never arrived", pending);
			timeouts++;
			abort = 1'b1;
		end
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		// random jobs are drawn up front with the centre start below the bound
		foreach (rand_jobs[i]) begin
			rand_jobs[i].base = 64 + rand_below(512);
			rand_jobs[i].stride = 64 + rand_below(64);
			rand_jobs[i].rows = 1 + rand_below(4);
			rand_jobs[i].vrows = rand_below(5);
			rand_jobs[i].bound = 1 + rand_below(40);
			rand_jobs[i].il = rand_below(rand_jobs[i].bound + 12) - 12;
			rand_jobs[i].n = 1 + rand_below(40);
			rand_jobs[i].pad = rand_below(VSIZE);
			rand_jobs[i].wrap = rand_below(2) != 0;
		end
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		send_fixed();
		drain_commands();
		// same jobs again under back-pressure
		test_id = 1;
		stall <= 1'b1;
		send_fixed();
		drain_commands();
		test_id = 2;
		foreach (rand_jobs[i]) begin
			send_job(rand_jobs[i]);
		end
		drain_commands();
		// an idle tail catches any stray command
		repeat (10) @(posedge clk);
		$display("errors: %0d mismatches, %0d other, %0d timeouts",
			mismatches, other_errors, timeouts);
		if (mismatches + other_errors + timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
